// ==== hdl/baudGen.sv ====
`timescale 1ns/1ps

module baudGen
   import uartPkg::*;
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  logic [DIV_W-1:0] baudDiv,
   output logic             brgClkEn
);

   //////////////////////////////
   // Divisor counter
   //////////////////////////////

   // Down counter, reloads from baudDiv at zero
   logic [DIV_W-1:0] count;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count    <= '0;
         brgClkEn <= 1'b0;
      end
      else if (clr)
      begin
         // Restart the period from zero
         count    <= '0;
         brgClkEn <= 1'b0;
      end
      else if (count == '0)
      begin
         // Wrap, new divisor picked up here
         count    <= baudDiv;
         brgClkEn <= 1'b1;
      end
      else
      begin
         count    <= count - 1'b1;
         brgClkEn <= 1'b0;
      end
   end

endmodule

// ==== hdl/charBuffer.sv ====
`timescale 1ns/1ps

module charBuffer
#(
   parameter type T         = logic [7:0],
   parameter bit  overwrite = 1'b0
)
(
   input  logic clk,
   input  logic rst,
   input  logic clr,
   input  logic wrStrobe,
   input  T     wrData,
   input  logic rdStrobe,
   output logic full,
   output T     data
);

   // Write lands when empty, or always in overwrite mode
   logic wrAccept;

   assign wrAccept = wrStrobe && (!full || overwrite);

   //////////////////////////////
   // Full flag
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         full <= 1'b0;
      else if (clr)
         full <= 1'b0;
      else if (wrAccept)
         full <= 1'b1;
      else if (rdStrobe)
         // Take or read empties the entry
         full <= 1'b0;
   end

   // Payload register
   always_ff @(posedge clk)
   begin
      if (wrAccept)
         data <= wrData;
   end

endmodule

// ==== hdl/uartPkg.sv ====
package uartPkg;

   //////////////////////////////
   // Line configuration types
   //////////////////////////////

   // Character length code, 5 to 8 data bits
   typedef enum logic [1:0]
   {
      len5 = 2'd0,
      len6 = 2'd1,
      len7 = 2'd2,
      len8 = 2'd3
   } uartLen_e;

   // Parity mode, last code behaves as no parity
   typedef enum logic [1:0]
   {
      parNone    = 2'd0,
      parEven    = 2'd1,
      parOdd     = 2'd2,
      parNoneAlt = 2'd3
   } uartPar_e;

   // Line settings shared by transmitter and receiver
   typedef struct packed
   {
      uartLen_e len;
      uartPar_e par;
      // Set for two stop bits
      logic     stop2;
   } uartCfg_t;

   //////////////////////////////
   // Received character
   //////////////////////////////

   // Data is LSB aligned, unused high bits read as zero
   typedef struct packed
   {
      logic [7:0] data;
      logic       parityErr;
      logic       framingErr;
   } rxChar_t;

   //////////////////////////////
   // Timing constants
   //////////////////////////////

   // Rate enables per bit time
   localparam int OVERSAMPLE = 16;
   // Enable count from bit start to mid-bit sample
   localparam int MID_SAMPLE = 7;
   // Width of the run-time rate divisor
   localparam int DIV_W      = 16;

endpackage

// ==== hdl/uartRx.sv ====
`timescale 1ns/1ps

module uartRx
   import uartPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     clr,
   input  uartCfg_t cfg,
   input  logic     brgClkEn,
   input  logic     rxd,
   output logic     done,
   output rxChar_t  char
);

   //////////////////////////////
   // Receive states
   //////////////////////////////

   typedef enum logic [2:0]
   {
      rxIdle,
      rxStart,
      rxData,
      rxParity,
      rxStop,
      // Line held low after a bad stop bit
      rxWaitHigh
   } rxState_e;

   rxState_e   state;
   logic [1:0] rxdMeta;
   logic       rxdSync;
   // Enables since the last sample point
   logic [3:0] cnt;
   logic [2:0] bitIdx;
   logic [2:0] lastIdx;
   logic [7:0] shReg;
   logic       parErr;
   logic       parOn;
   logic       expPar;
   logic       tick;
   logic       confirmTick;

   // Two flop synchronizer, idles high like the line
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rxdMeta <= 2'b11;
      else
         rxdMeta <= {rxdMeta[0], rxd};
   end

   assign rxdSync = rxdMeta[1];

   // Index of last data bit, 4 to 7
   assign lastIdx = {1'b1, cfg.len};
   assign parOn   = (cfg.par == parEven) || (cfg.par == parOdd);
   // Unused high bits are zero so the full byte works
   assign expPar  = (^shReg) ^ (cfg.par == parOdd);

   // Sample points in enable counts
   assign tick        = brgClkEn && (cnt == 4'(OVERSAMPLE - 1));
   assign confirmTick = brgClkEn && (cnt == 4'(MID_SAMPLE - 1));

   //////////////////////////////
   // State machine
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= rxIdle;
         cnt    <= '0;
         bitIdx <= '0;
         done   <= 1'b0;
      end
      else if (clr)
      begin
         state  <= rxIdle;
         cnt    <= '0;
         bitIdx <= '0;
         done   <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (brgClkEn)
            cnt <= cnt + 1'b1;
         case (state)
            // Hunt for a low line at an enable
            rxIdle:
               if (brgClkEn && !rxdSync)
               begin
                  cnt   <= '0;
                  state <= rxStart;
               end
            // Still low at mid start bit or a glitch
            rxStart:
               if (confirmTick)
               begin
                  cnt    <= '0;
                  bitIdx <= '0;
                  state  <= rxdSync ? rxIdle : rxData;
               end
            rxData:
               if (tick)
               begin
                  cnt    <= '0;
                  bitIdx <= bitIdx + 1'b1;
                  if (bitIdx == lastIdx)
                     state <= parOn ? rxParity : rxStop;
               end
            rxParity:
               if (tick)
               begin
                  cnt   <= '0;
                  state <= rxStop;
               end
            // Character complete at first stop sample
            rxStop:
               if (tick)
               begin
                  cnt   <= '0;
                  done  <= 1'b1;
                  state <= rxdSync ? rxIdle : rxWaitHigh;
               end
            rxWaitHigh:
               if (brgClkEn && rxdSync)
                  state <= rxIdle;
            default:
               state <= rxIdle;
         endcase
      end
   end

   //////////////////////////////
   // Data path
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      // Fresh character, clear stale bits and flag
      if ((state == rxStart) && confirmTick)
      begin
         shReg  <= '0;
         parErr <= 1'b0;
      end
      // LSB first into the bit position
      if ((state == rxData) && tick)
         shReg[bitIdx] <= rxdSync;
      if ((state == rxParity) && tick)
         parErr <= (rxdSync != expPar);
      if ((state == rxStop) && tick)
      begin
         char.data       <= shReg;
         char.parityErr  <= parErr;
         // Low first stop bit is a framing error
         char.framingErr <= ~rxdSync;
      end
   end

endmodule

// ==== hdl/uartTop.sv ====
`timescale 1ns/1ps

module uartTop
   import uartPkg::*;
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  uartCfg_t         cfg,
   input  logic [DIV_W-1:0] baudDiv,
   input  logic [7:0]       txData,
   input  logic             txWrite,
   input  logic             rxRead,
   input  logic             rxd,
   output logic             txFull,
   output logic             txEmpty,
   output logic             txIntr,
   output logic             txd,
   output logic             rxValid,
   output rxChar_t          rxChar,
   output logic             rxIntr
);

   logic       brgClkEn;
   // Transmit buffer to transmitter
   logic       txTake;
   logic [7:0] txBufData;
   // Receiver to receive buffer
   logic       rxDone;
   rxChar_t    rxNew;

   // Shared 16x bit rate enable
   baudGen uBaud
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .baudDiv  (baudDiv),
      .brgClkEn (brgClkEn)
   );

   //////////////////////////////
   // Transmit side
   //////////////////////////////

   // Host writes to a full buffer are dropped
   charBuffer #(.T(logic [7:0]), .overwrite(1'b0)) uTxBuf
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .wrStrobe (txWrite),
      .wrData   (txData),
      .rdStrobe (txTake),
      .full     (txFull),
      .data     (txBufData)
   );

   uartTx uTx
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .cfg      (cfg),
      .brgClkEn (brgClkEn),
      .load     (txFull),
      .data     (txBufData),
      .take     (txTake),
      .empty    (txEmpty),
      .intr     (txIntr),
      .txd      (txd)
   );

   //////////////////////////////
   // Receive side
   //////////////////////////////

   uartRx uRx
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .cfg      (cfg),
      .brgClkEn (brgClkEn),
      .rxd      (rxd),
      .done     (rxDone),
      .char     (rxNew)
   );

   // Newest character replaces an unread one
   charBuffer #(.T(rxChar_t), .overwrite(1'b1)) uRxBuf
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .wrStrobe (rxDone),
      .wrData   (rxNew),
      .rdStrobe (rxRead),
      .full     (rxValid),
      .data     (rxChar)
   );

   // Interrupt on each completed character
   assign rxIntr = rxDone;

endmodule

// ==== hdl/uartTx.sv ====
`timescale 1ns/1ps

module uartTx
   import uartPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clr,
   input  uartCfg_t   cfg,
   input  logic       brgClkEn,
   input  logic       load,
   input  logic [7:0] data,
   output logic       take,
   output logic       empty,
   output logic       intr,
   output logic       txd
);

   //////////////////////////////
   // Frame states
   //////////////////////////////

   typedef enum logic [3:0]
   {
      txIdle, txSync, txStart,
      txBit0, txBit1, txBit2, txBit3,
      txBit4, txBit5, txBit6, txBit7,
      txParity, txStop1, txStop2, txDone
   } txState_e;

   txState_e   state;
   txState_e   nextBit;
   txState_e   afterData;
   // Enables left in the current bit
   logic [3:0] brDiv;
   logic [7:0] txReg;
   logic [7:0] lenMask;
   logic       parOn;
   logic       evenPar;
   logic       txBit;

   assign parOn = (cfg.par == parEven) || (cfg.par == parOdd);

   // Parity bit or first stop after last data bit
   assign afterData = parOn ? txParity : txStop1;

   // Next state at the end of a bit time
   always_comb
   begin
      case (state)
         txStart  : nextBit = txBit0;
         txBit0   : nextBit = txBit1;
         txBit1   : nextBit = txBit2;
         txBit2   : nextBit = txBit3;
         txBit3   : nextBit = txBit4;
         // Short characters skip the upper bits
         txBit4   : nextBit = (cfg.len == len5) ? afterData : txBit5;
         txBit5   : nextBit = (cfg.len == len6) ? afterData : txBit6;
         txBit6   : nextBit = (cfg.len == len7) ? afterData : txBit7;
         txBit7   : nextBit = afterData;
         txParity : nextBit = txStop1;
         txStop1  : nextBit = cfg.stop2 ? txStop2 : txDone;
         txStop2  : nextBit = txDone;
         default  : nextBit = txIdle;
      endcase
   end

   //////////////////////////////
   // State machine
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= txIdle;
         brDiv <= '0;
      end
      else if (clr)
      begin
         state <= txIdle;
         brDiv <= '0;
      end
      else
      begin
         case (state)
            txIdle:
               if (load)
                  state <= txSync;
            // Align the start bit to an enable
            txSync:
               if (brgClkEn)
               begin
                  brDiv <= 4'(OVERSAMPLE - 1);
                  state <= txStart;
               end
            // One clock for the interrupt pulse
            txDone:
               state <= txIdle;
            default:
               if (brgClkEn)
               begin
                  if (brDiv == '0)
                  begin
                     brDiv <= 4'(OVERSAMPLE - 1);
                     state <= nextBit;
                  end
                  else
                     brDiv <= brDiv - 1'b1;
               end
         endcase
      end
   end

   // Character latched as the buffer is taken
   always_ff @(posedge clk)
   begin
      if (take)
         txReg <= data;
   end

   //////////////////////////////
   // Parity and output select
   //////////////////////////////

   // Mask off bits beyond the character length
   assign lenMask = 8'hff >> (2'd3 - cfg.len);
   assign evenPar = ^(txReg & lenMask);

   always_comb
   begin
      case (state)
         txStart  : txBit = 1'b0;
         txBit0   : txBit = txReg[0];
         txBit1   : txBit = txReg[1];
         txBit2   : txBit = txReg[2];
         txBit3   : txBit = txReg[3];
         txBit4   : txBit = txReg[4];
         txBit5   : txBit = txReg[5];
         txBit6   : txBit = txReg[6];
         txBit7   : txBit = txReg[7];
         // Odd parity is the complement of even
         txParity : txBit = (cfg.par == parOdd) ? ~evenPar : evenPar;
         default  : txBit = 1'b1;
      endcase
   end

   assign take  = (state == txIdle) && load;
   assign empty = (state == txIdle);
   assign intr  = (state == txDone);
   assign txd   = txBit;

endmodule

// ==== testbench/uartTop_chk.sv ====
`timescale 1ns/1ps

module uartTop_chk
(
   input logic clk,
   input logic rst,
   input logic clr,
   input logic rxRead,
   input logic txEmpty,
   input logic txd,
   input logic txIntr,
   input logic rxIntr,
   input logic rxValid
);

   // Assertion failures so far, read by the testbench at the end
   int failCount = 0;

   //////////////////////////////
   // Port properties
   //////////////////////////////

   // Idle transmitter holds the line at mark
   idleMark: assert property (@(posedge clk) disable iff (rst) txEmpty |-> txd)
   else
   begin
      failCount++;
      $error("txd low while the transmitter is idle");
   end

   // Interrupts are single-cycle pulses
   txPulse: assert property (@(posedge clk) disable iff (rst) txIntr |=> !txIntr)
   else
   begin
      failCount++;
      $error("txIntr high on two consecutive cycles");
   end

   rxPulse: assert property (@(posedge clk) disable iff (rst) rxIntr |=> !rxIntr)
   else
   begin
      failCount++;
      $error("rxIntr high on two consecutive cycles");
   end

   // Only a read or a clear empties the rx buffer
   rxHold: assert property (@(posedge clk) disable iff (rst)
      rxValid && !rxRead && !clr |=> rxValid)
   else
   begin
      failCount++;
      $error("rxValid dropped without rxRead");
   end

endmodule

bind uartTop uartTop_chk uChk
(
   .clk     (clk),
   .rst     (rst),
   .clr     (clr),
   .rxRead  (rxRead),
   .txEmpty (txEmpty),
   .txd     (txd),
   .txIntr  (txIntr),
   .rxIntr  (rxIntr),
   .rxValid (rxValid)
);

// ==== testbench/uartTop_tb.sv ====
`timescale 1ns/1ps

module uartTop_tb
   import uartPkg::*;
();

   //////////////////////////////
   // Timing and table sizes
   //////////////////////////////

   localparam int CLK_PERIOD   = 8;
   localparam int BAUD_DIV     = 1;
   // Clocks per bit on the line
   localparam int BIT_CLK      = OVERSAMPLE * (BAUD_DIV + 1);
   // Longest frame with margin for the enable phase
   localparam int FRAME_CYCLES = 13 * BIT_CLK;
   localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
   localparam int NUM_ROWS     = 13;
   localparam int RAND_PER_ROW = 8;
   // Buffering, overwrite and clear sequences
   localparam int EXTRA_FRAMES = 8;
   localparam int TOTAL_FRAMES = NUM_ROWS * (1 + RAND_PER_ROW) + EXTRA_FRAMES;
   localparam int WATCHDOG_NS  = (TOTAL_FRAMES * FRAME_CYCLES + 5000) * CLK_PERIOD;

   // One stimulus case
   typedef struct packed
   {
      uartCfg_t   cfg;
      logic [7:0] data;
      logic       bitBang;
      logic       badPar;
      logic       badStop;
   } stimRow_t;

   logic             clk;
   logic             rst;
   logic             clr;
   uartCfg_t         cfg;
   logic [DIV_W-1:0] baudDiv;
   logic [7:0]       txData;
   logic             txWrite;
   logic             rxRead;
   logic             rxd;
   logic             txFull;
   logic             txEmpty;
   logic             txIntr;
   logic             txd;
   logic             rxValid;
   rxChar_t          rxChar;
   logic             rxIntr;

   // Serial source select and bit-bang line
   logic     loopSel;
   logic     bbRxd;
   stimRow_t rows [NUM_ROWS];
   integer   seed = 49;
   integer   randWord;
   int       rxIntrCount = 0;
   int       txIntrCount = 0;
   int       rxBase;
   int       txBase;

   assign rxd = loopSel ? txd : bbRxd;

   uartTop DUT
   (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .cfg     (cfg),
      .baudDiv (baudDiv),
      .txData  (txData),
      .txWrite (txWrite),
      .rxRead  (rxRead),
      .rxd     (rxd),
      .txFull  (txFull),
      .txEmpty (txEmpty),
      .txIntr  (txIntr),
      .txd     (txd),
      .rxValid (rxValid),
      .rxChar  (rxChar),
      .rxIntr  (rxIntr)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Interrupt pulses counted mid-cycle
   always @(negedge clk)
   begin
      if (rxIntr)
         rxIntrCount++;
      if (txIntr)
         txIntrCount++;
      // Any failed port property ends the run at once
      if (DUT.uChk.failCount != 0)
         abortRun("The bound checker reported a failed assertion on the DUT ports");
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run aborted by watchdog");
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic stimRow_t makeRow(uartLen_e len, uartPar_e par, logic stop2,
                                        logic [7:0] data, logic bitBang, logic badPar,
                                        logic badStop);
      stimRow_t r;
      r.cfg.len   = len;
      r.cfg.par   = par;
      r.cfg.stop2 = stop2;
      r.data      = data;
      r.bitBang   = bitBang;
      r.badPar    = badPar;
      r.badStop   = badStop;
      return r;
   endfunction

   function automatic logic parityOn(uartCfg_t c);
      return (c.par == parEven) || (c.par == parOdd);
   endfunction

   // Even parity over the used bits with odd as its complement
   function automatic logic parityBit(uartCfg_t c, logic [7:0] d);
      logic p;
      p = 1'b0;
      for (int i = 0; i < 5 + int'(c.len); i++)
         p ^= d[i];
      return (c.par == parOdd) ? ~p : p;
   endfunction

   function automatic rxChar_t expectChar(uartCfg_t c, logic [7:0] d, logic badPar,
                                          logic badStop);
      rxChar_t    e;
      logic [8:0] mask;
      mask         = (9'd1 << (5 + int'(c.len))) - 9'd1;
      e.data       = d & mask[7:0];
      e.parityErr  = parityOn(c) && badPar;
      e.framingErr = badStop;
      return e;
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic abortRun(string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkChar(string name, rxChar_t got, rxChar_t exp);
      string msg;
      if (got !== exp)
      begin
         msg = $sformatf("FAIL time %0t %s got data %h parityErr %b framingErr %b", $time,
                         name, got.data, got.parityErr, got.framingErr);
         msg = {msg, $sformatf(", expected data %h parityErr %b framingErr %b", exp.data,
                               exp.parityErr, exp.framingErr)};
         abortRun(msg);
      end
   endtask

   task automatic checkLevel(string name, logic got, logic exp);
      if (got !== exp)
         abortRun($sformatf("FAIL time %0t %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic checkCount(string name, int got, int exp);
      if (got != exp)
         abortRun($sformatf("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic checkIdleStatus();
      checkLevel("txEmpty", txEmpty, 1'b1);
      checkLevel("txFull", txFull, 1'b0);
      checkLevel("rxValid", rxValid, 1'b0);
      checkLevel("txIntr", txIntr, 1'b0);
      checkLevel("rxIntr", rxIntr, 1'b0);
      checkLevel("txd", txd, 1'b1);
   endtask

   //////////////////////////////
   // Drivers
   //////////////////////////////

   // Counts are read on rising edges away from the counting edge
   task automatic waitIntrs(int rxTarget, int txTarget, string what);
      int cycles;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abortRun($sformatf("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what));
      end
      while ((rxIntrCount < rxTarget) || (txIntrCount < txTarget));
      @(negedge clk);
   endtask

   task automatic writeTx(logic [7:0] d);
      txData  = d;
      txWrite = 1'b1;
      @(negedge clk);
      txWrite = 1'b0;
   endtask

   task automatic readRx();
      rxRead = 1'b1;
      @(negedge clk);
      rxRead = 1'b0;
   endtask

   task automatic driveBit(logic b);
      bbRxd = b;
      repeat (BIT_CLK) @(negedge clk);
   endtask

   // Whole frame on rxd LSB first followed by one idle bit
   task automatic sendSerial(uartCfg_t c, logic [7:0] d, logic badPar, logic badStop);
      driveBit(1'b0);
      for (int i = 0; i < 5 + int'(c.len); i++)
         driveBit(d[i]);
      if (parityOn(c))
         driveBit(parityBit(c, d) ^ badPar);
      driveBit(!badStop);
      if (c.stop2)
         driveBit(1'b1);
      driveBit(1'b1);
   endtask

   task automatic runFrame(stimRow_t r, logic [7:0] d);
      rxChar_t exp;
      exp     = expectChar(r.cfg, d, r.badPar, r.badStop);
      rxBase  = rxIntrCount;
      txBase  = txIntrCount;
      cfg     = r.cfg;
      loopSel = !r.bitBang;
      if (r.bitBang)
      begin
         sendSerial(r.cfg, d, r.badPar, r.badStop);
         waitIntrs(rxBase + 1, txBase, "bit-bang character");
      end
      else
      begin
         writeTx(d);
         waitIntrs(rxBase + 1, txBase + 1, "loopback character");
      end
      checkLevel("rxValid", rxValid, 1'b1);
      checkChar("rxChar", rxChar, exp);
      checkCount("rxIntr count", rxIntrCount, rxBase + 1);
      checkCount("txIntr count", txIntrCount, r.bitBang ? txBase : txBase + 1);
      readRx();
      checkLevel("rxValid", rxValid, 1'b0);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      rst     = 1'b1;
      clr     = 1'b0;
      cfg     = '0;
      baudDiv = DIV_W'(BAUD_DIV);
      txData  = '0;
      txWrite = 1'b0;
      rxRead  = 1'b0;
      loopSel = 1'b1;
      bbRxd   = 1'b1;

      // Loopback rows cover every length, parity mode and stop count
      rows[0]  = makeRow(len5, parNone,    1'b0, 8'hA5, 1'b0, 1'b0, 1'b0);
      rows[1]  = makeRow(len6, parEven,    1'b1, 8'h3C, 1'b0, 1'b0, 1'b0);
      rows[2]  = makeRow(len7, parOdd,     1'b0, 8'h5A, 1'b0, 1'b0, 1'b0);
      rows[3]  = makeRow(len8, parNoneAlt, 1'b1, 8'hC3, 1'b0, 1'b0, 1'b0);
      rows[4]  = makeRow(len8, parEven,    1'b0, 8'h96, 1'b0, 1'b0, 1'b0);
      rows[5]  = makeRow(len5, parOdd,     1'b1, 8'hFF, 1'b0, 1'b0, 1'b0);
      rows[6]  = makeRow(len6, parNone,    1'b0, 8'h81, 1'b0, 1'b0, 1'b0);
      rows[7]  = makeRow(len7, parEven,    1'b1, 8'h7E, 1'b0, 1'b0, 1'b0);
      // Bit-bang rows with corrupted parity or stop
      rows[8]  = makeRow(len8, parEven,    1'b0, 8'h12, 1'b1, 1'b1, 1'b0);
      rows[9]  = makeRow(len7, parOdd,     1'b1, 8'h6B, 1'b1, 1'b1, 1'b0);
      rows[10] = makeRow(len8, parNone,    1'b0, 8'h34, 1'b1, 1'b0, 1'b1);
      rows[11] = makeRow(len6, parEven,    1'b0, 8'h2D, 1'b1, 1'b1, 1'b1);
      rows[12] = makeRow(len5, parNone,    1'b1, 8'h11, 1'b1, 1'b0, 1'b0);

      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      checkIdleStatus();

      // Table byte first, then random bytes with the same settings
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         for (int k = 0; k <= RAND_PER_ROW; k++)
         begin
            randWord = $random(seed);
            runFrame(rows[r], (k == 0) ? rows[r].data : randWord[7:0]);
         end
      end

      // Second write waits behind the first and the third is dropped
      loopSel = 1'b1;
      cfg     = rows[4].cfg;
      rxBase  = rxIntrCount;
      txBase  = txIntrCount;
      writeTx(8'h5C);
      checkLevel("txFull", txFull, 1'b1);
      @(negedge clk);
      checkLevel("txFull", txFull, 1'b0);
      checkLevel("txEmpty", txEmpty, 1'b0);
      writeTx(8'hE7);
      writeTx(8'h01);
      checkLevel("txFull", txFull, 1'b1);
      waitIntrs(rxBase + 1, txBase, "first buffered character");
      checkLevel("txFull", txFull, 1'b1);
      checkChar("rxChar", rxChar, expectChar(cfg, 8'h5C, 1'b0, 1'b0));
      readRx();
      waitIntrs(rxBase + 2, txBase + 2, "second buffered character");
      checkChar("rxChar", rxChar, expectChar(cfg, 8'hE7, 1'b0, 1'b0));
      checkLevel("txFull", txFull, 1'b0);
      checkLevel("txEmpty", txEmpty, 1'b1);
      checkCount("rxIntr count", rxIntrCount, rxBase + 2);
      readRx();

      // Unread character replaced by the next one
      cfg    = rows[2].cfg;
      rxBase = rxIntrCount;
      txBase = txIntrCount;
      writeTx(8'h2A);
      waitIntrs(rxBase + 1, txBase + 1, "character left unread");
      checkLevel("rxValid", rxValid, 1'b1);
      writeTx(8'h55);
      waitIntrs(rxBase + 2, txBase + 2, "overwriting character");
      checkLevel("rxValid", rxValid, 1'b1);
      checkChar("rxChar", rxChar, expectChar(cfg, 8'h55, 1'b0, 1'b0));
      readRx();
      checkLevel("rxValid", rxValid, 1'b0);

      // Clear in mid-frame with a character still buffered
      cfg = rows[3].cfg;
      writeTx(8'h0F);
      @(negedge clk);
      writeTx(8'hF0);
      repeat (4 * BIT_CLK) @(negedge clk);
      checkLevel("txFull", txFull, 1'b1);
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
      checkIdleStatus();
      rxBase = rxIntrCount;
      txBase = txIntrCount;
      repeat (16 * BIT_CLK) @(negedge clk);
      checkCount("rxIntr count", rxIntrCount, rxBase);
      checkCount("txIntr count", txIntrCount, txBase);
      checkLevel("txd", txd, 1'b1);

      if (DUT.uChk.failCount == 0)
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
      else
      begin
         $display("%0d concurrent assertion failures", DUT.uChk.failCount);
         $display("TESTBENCH FAILED");
         $fatal(1, "Checker reported assertion failures");
      end
   end

endmodule

// ==== verilog.f ====
hdl/uartPkg.sv
hdl/baudGen.sv
hdl/charBuffer.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartTop.sv
testbench/uartTop_chk.sv
testbench/uartTop_tb.sv
